//--- rtl/cdp_lut_consts.svh
/*
 * Shared sizes for the CDP LUT index controller.
 * Word layout (lanes, elements, sum width), table start and shift
 * widths, entry and info widths, and the LE/LO table depths.
 */
`ifndef CDP_LUT_CONSTS_SVH
`define CDP_LUT_CONSTS_SVH

`define CDP_LUT_LANES       4     // lanes per sum word
`define CDP_LUT_ELEMS       8     // two sums per lane
`define CDP_LUT_SUM_W       21    // one signed sum
`define CDP_LUT_LANE_W      42    // low sum + high sum
`define CDP_LUT_PD_W        168   // whole word

`define CDP_LUT_START_W     32    // signed table start
`define CDP_LUT_SHIFT_W     5     // low bits of index_select
`define CDP_LUT_ENTRY_W     10    // entry number
`define CDP_LUT_FRAC_W      16    // left aligned fraction
`define CDP_LUT_INFO_W      18    // uflow, oflow, fraction

`define CDP_LUT_LE_ENTRIES  65
`define CDP_LUT_LO_ENTRIES  257

`endif

//--- rtl/cdp_lut_pkg.sv
/*
 * Vector types for the CDP LUT index controller: signed sums and the
 * packed sum word, table start and shift, entry and info, and the
 * eight-element entry and info vectors (element 0 in the low bits).
 */
`include "cdp_lut_consts.svh"

package cdp_lut_pkg;

  ////////////////////////////////////////////////////////////
  // input side
  typedef logic signed [`CDP_LUT_SUM_W-1:0]   sum_t;       // one element
  typedef logic        [`CDP_LUT_PD_W-1:0]    sum_pd_t;    // four lanes

  ////////////////////////////////////////////////////////////
  // configuration
  typedef logic signed [`CDP_LUT_START_W-1:0] lut_start_t;
  typedef logic        [`CDP_LUT_SHIFT_W-1:0] lut_shift_t;

  ////////////////////////////////////////////////////////////
  // results
  typedef logic [`CDP_LUT_ENTRY_W-1:0] lut_entry_t;
  typedef logic [`CDP_LUT_INFO_W-1:0]  lut_info_t;         // {uflow, oflow, frac}

  typedef logic [`CDP_LUT_ELEMS*`CDP_LUT_ENTRY_W-1:0] entry_vec_t;
  typedef logic [`CDP_LUT_ELEMS*`CDP_LUT_INFO_W-1:0]  info_vec_t;

endpackage

//--- rtl/cdp_lut_index.sv
/*
 * Linear LUT index for one element against one table.
 * Subtracts the table start, clamps underflow to entry 0 and
 * overflow to the last entry, and left-aligns the bits dropped
 * by the shift into a 16-bit fraction.
 */
`timescale 1ns/100ps
`include "cdp_lut_consts.svh"

module cdp_lut_index #(
  parameter int ENTRIES = `CDP_LUT_LE_ENTRIES
) (
  input  cdp_lut_pkg::sum_t        sum,
  input  cdp_lut_pkg::lut_start_t  start,
  input  cdp_lut_pkg::lut_shift_t  shift,
  output cdp_lut_pkg::lut_entry_t  entry,
  output cdp_lut_pkg::lut_info_t   info
);

  localparam int DIFF_W  = `CDP_LUT_START_W + 1;
  localparam int SUM_W   = `CDP_LUT_SUM_W;
  localparam int FRAC_W  = `CDP_LUT_FRAC_W;
  localparam int SHIFT_W = `CDP_LUT_SHIFT_W;
  localparam int ENTRY_W = `CDP_LUT_ENTRY_W;
  localparam logic [DIFF_W-1:0] LAST = DIFF_W'(ENTRIES - 1);

  logic signed [DIFF_W-1:0]  diff;         // x - start, never wraps
  logic        [DIFF_W-1:0]  idx;
  logic                      uflow;
  logic                      oflow;
  logic        [FRAC_W-1:0]  frac_raw;

  assign diff = {{(DIFF_W-SUM_W){sum[SUM_W-1]}}, sum} - {start[DIFF_W-2], start};

  assign uflow = diff[DIFF_W-1];
  assign idx   = diff >> shift;
  assign oflow = ~uflow & (idx >= LAST);

  // low shift bits of diff, left aligned; wide shifts keep the top 16
  always_comb begin
    if (shift > SHIFT_W'(FRAC_W)) begin
      frac_raw = FRAC_W'(diff >> (shift - SHIFT_W'(FRAC_W)));
    end else begin
      frac_raw = FRAC_W'(diff[FRAC_W-1:0] << (SHIFT_W'(FRAC_W) - shift));
    end
  end

  always_comb begin
    if (uflow) begin
      entry = '0;
    end else if (oflow) begin
      entry = LAST[ENTRY_W-1:0];            // clamp to last entry
    end else begin
      entry = idx[ENTRY_W-1:0];
    end
  end

  assign info = {uflow, oflow, (uflow | oflow) ? {FRAC_W{1'b0}} : frac_raw};

endmodule

//--- rtl/cdp_lut_decode.sv
/*
 * Input stage of the LUT index controller.
 * One-deep register slice for the sum word, forked to the sync
 * port and to the result stage; the word is released only when
 * both consumers take it in the same cycle.
 */
`timescale 1ns/100ps

module cdp_lut_decode (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  // sum word in
  input  logic                  sum_pvld,
  input  cdp_lut_pkg::sum_pd_t  sum_pd,
  output logic                  sum_prdy,
  // copy for the interpolation FIFO
  output logic                  sync_pvld,
  output cdp_lut_pkg::sum_pd_t  sync_pd,
  input  logic                  sync_prdy,
  // copy for the index stage
  output logic                  dec_pvld,
  output cdp_lut_pkg::sum_pd_t  dec_pd,
  input  logic                  res_prdy
);

  import cdp_lut_pkg::*;

  logic     full;       // slice holds a word
  logic     leave;      // both sides take it this cycle
  sum_pd_t  pd_q;

  ////////////////////////////////////////////////////////////
  // slice control

  assign leave    = full & sync_prdy & res_prdy;
  assign sum_prdy = ~full | leave;          // one word per cycle

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      full <= 1'b0;
    end else if (sum_prdy) begin
      full <= sum_pvld;                     // refill or drain
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (sum_pvld & sum_prdy) begin
      pd_q <= sum_pd;
    end
  end

  ////////////////////////////////////////////////////////////
  // fork
  // each side sees valid only while the other side can also take
  // the word, so a transfer on one side is always a joint one

  assign sync_pvld = full & res_prdy;
  assign dec_pvld  = full & sync_prdy;

  assign sync_pd = pd_q;                    // unchanged copy
  assign dec_pd  = pd_q;

endmodule

//--- rtl/cdp_lut_result.sv
/*
 * Index stage of the LUT controller.
 * Unpacks eight elements from the sum word, runs each against the
 * LE (X) and LO (Y) tables, and registers all sixteen results in
 * one output stage with its own valid/ready.
 */
`timescale 1ns/100ps
`include "cdp_lut_consts.svh"

module cdp_lut_result (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  // word from decode
  input  logic                     dec_pvld,
  input  cdp_lut_pkg::sum_pd_t     dec_pd,
  output logic                     res_prdy,
  // table configuration, held while words are in flight
  input  cdp_lut_pkg::lut_start_t  le_start,
  input  cdp_lut_pkg::lut_start_t  lo_start,
  input  logic [7:0]               le_index_select,
  input  logic [7:0]               lo_index_select,
  // results
  output logic                     lut_pvld,
  input  logic                     lut_prdy,
  output cdp_lut_pkg::entry_vec_t  lut_x_entry,
  output cdp_lut_pkg::info_vec_t   lut_x_info,
  output cdp_lut_pkg::entry_vec_t  lut_y_entry,
  output cdp_lut_pkg::info_vec_t   lut_y_info
);

  import cdp_lut_pkg::*;

  localparam int ELEMS   = `CDP_LUT_ELEMS;
  localparam int LANES   = `CDP_LUT_LANES;
  localparam int LANE_W  = `CDP_LUT_LANE_W;
  localparam int SUM_W   = `CDP_LUT_SUM_W;
  localparam int ENTRY_W = `CDP_LUT_ENTRY_W;
  localparam int INFO_W  = `CDP_LUT_INFO_W;

  lut_shift_t  le_shift;
  lut_shift_t  lo_shift;
  entry_vec_t  x_entry_nxt;
  entry_vec_t  y_entry_nxt;
  info_vec_t   x_info_nxt;
  info_vec_t   y_info_nxt;

  assign le_shift = le_index_select[`CDP_LUT_SHIFT_W-1:0];   // upper bits unused
  assign lo_shift = lo_index_select[`CDP_LUT_SHIFT_W-1:0];

  ////////////////////////////////////////////////////////////
  // element e: lane e%4, low sum for e<4 and high sum otherwise

  for (genvar e = 0; e < ELEMS; e++) begin : g_elem
    localparam int BASE = (e % LANES) * LANE_W + (e / LANES) * SUM_W;

    sum_t elem;

    assign elem = dec_pd[BASE +: SUM_W];

    cdp_lut_index #(.ENTRIES(`CDP_LUT_LE_ENTRIES)) u_le (
      .sum   (elem),
      .start (le_start),
      .shift (le_shift),
      .entry (x_entry_nxt[e*ENTRY_W +: ENTRY_W]),
      .info  (x_info_nxt[e*INFO_W +: INFO_W])
    );

    cdp_lut_index #(.ENTRIES(`CDP_LUT_LO_ENTRIES)) u_lo (
      .sum   (elem),
      .start (lo_start),
      .shift (lo_shift),
      .entry (y_entry_nxt[e*ENTRY_W +: ENTRY_W]),
      .info  (y_info_nxt[e*INFO_W +: INFO_W])
    );
  end

  ////////////////////////////////////////////////////////////
  // output stage

  assign res_prdy = ~lut_pvld | lut_prdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      lut_pvld <= 1'b0;
    end else if (res_prdy) begin
      lut_pvld <= dec_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (dec_pvld & res_prdy) begin
      lut_x_entry <= x_entry_nxt;
      lut_x_info  <= x_info_nxt;
      lut_y_entry <= y_entry_nxt;
      lut_y_info  <= y_info_nxt;
    end
  end

endmodule

//--- rtl/cdp_lut_ctrl.sv
/*
 * Top level of the CDP LUT index controller.
 * Decode slice forks the sum word to the sync port and to the
 * result stage, which drives the LE/LO entry and info outputs.
 */
`timescale 1ns/100ps

module cdp_lut_ctrl (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  // sum word
  input  logic                     sum_pvld,
  input  cdp_lut_pkg::sum_pd_t     sum_pd,
  output logic                     sum_prdy,
  // interpolation FIFO side
  output logic                     sync_pvld,
  output cdp_lut_pkg::sum_pd_t     sync_pd,
  input  logic                     sync_prdy,
  // configuration
  input  cdp_lut_pkg::lut_start_t  le_start,
  input  cdp_lut_pkg::lut_start_t  lo_start,
  input  logic [7:0]               le_index_select,
  input  logic [7:0]               lo_index_select,
  // LUT side, X from LE and Y from LO
  output logic                     lut_pvld,
  input  logic                     lut_prdy,
  output cdp_lut_pkg::entry_vec_t  lut_x_entry,
  output cdp_lut_pkg::info_vec_t   lut_x_info,
  output cdp_lut_pkg::entry_vec_t  lut_y_entry,
  output cdp_lut_pkg::info_vec_t   lut_y_info
);

  import cdp_lut_pkg::*;

  logic     dec_pvld;
  sum_pd_t  dec_pd;
  logic     res_prdy;

  cdp_lut_decode u_decode (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .sum_pvld        (sum_pvld),
    .sum_pd          (sum_pd),
    .sum_prdy        (sum_prdy),
    .sync_pvld       (sync_pvld),
    .sync_pd         (sync_pd),
    .sync_prdy       (sync_prdy),
    .dec_pvld        (dec_pvld),
    .dec_pd          (dec_pd),
    .res_prdy        (res_prdy)
  );

  cdp_lut_result u_result (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .dec_pvld        (dec_pvld),
    .dec_pd          (dec_pd),
    .res_prdy        (res_prdy),
    .le_start        (le_start),
    .lo_start        (lo_start),
    .le_index_select (le_index_select),
    .lo_index_select (lo_index_select),
    .lut_pvld        (lut_pvld),
    .lut_prdy        (lut_prdy),
    .lut_x_entry     (lut_x_entry),
    .lut_x_info      (lut_x_info),
    .lut_y_entry     (lut_y_entry),
    .lut_y_info      (lut_y_info)
  );

endmodule

//--- test/cdp_lut_ctrl_assert.sv
/*
 * Handshake assertions bound to the LUT controller top level:
 * stall stability on the sum, sync and lut ports, and quiet
 * valids in the first cycle after reset.
 */
`timescale 1ns/100ps

module cdp_lut_ctrl_assert (
  input logic                     nvdla_core_clk,
  input logic                     nvdla_core_rstn,
  input logic                     sum_pvld,
  input cdp_lut_pkg::sum_pd_t     sum_pd,
  input logic                     sum_prdy,
  input logic                     sync_pvld,
  input cdp_lut_pkg::sum_pd_t     sync_pd,
  input logic                     sync_prdy,
  input logic                     dec_pvld,
  input logic                     res_prdy,
  input logic                     lut_pvld,
  input logic                     lut_prdy,
  input cdp_lut_pkg::entry_vec_t  lut_x_entry,
  input cdp_lut_pkg::info_vec_t   lut_x_info,
  input cdp_lut_pkg::entry_vec_t  lut_y_entry,
  input cdp_lut_pkg::info_vec_t   lut_y_info
);

  int fail_count = 0;                       // read by the testbench at the end

  sum_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    sum_pvld && !sum_prdy |=> sum_pvld && $stable(sum_pd))
    else begin
      fail_count++;
      $error("sum word dropped or changed while stalled");
    end

  // sync valid may only fall when the result side is stalled
  sync_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    sync_pvld && !sync_prdy |=> $stable(sync_pd) && (sync_pvld || !res_prdy))
    else begin
      fail_count++;
      $error("sync word dropped or changed while stalled");
    end

  lut_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    lut_pvld && !lut_prdy |=> lut_pvld && $stable({lut_x_entry, lut_x_info,
                                                   lut_y_entry, lut_y_info}))
    else begin
      fail_count++;
      $error("lut result dropped or changed while stalled");
    end

  quiet_after_reset: assert property (@(posedge nvdla_core_clk)
    disable iff (!nvdla_core_rstn)
    $rose(nvdla_core_rstn) |-> !sync_pvld && !dec_pvld && !lut_pvld)
    else begin
      fail_count++;
      $error("valid high in the first cycle after reset");
    end

endmodule

bind cdp_lut_ctrl cdp_lut_ctrl_assert u_assert (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .sum_pvld        (sum_pvld),
  .sum_pd          (sum_pd),
  .sum_prdy        (sum_prdy),
  .sync_pvld       (sync_pvld),
  .sync_pd         (sync_pd),
  .sync_prdy       (sync_prdy),
  .dec_pvld        (dec_pvld),
  .res_prdy        (res_prdy),
  .lut_pvld        (lut_pvld),
  .lut_prdy        (lut_prdy),
  .lut_x_entry     (lut_x_entry),
  .lut_x_info      (lut_x_info),
  .lut_y_entry     (lut_y_entry),
  .lut_y_info      (lut_y_info)
);

//--- test/cdp_lut_ctrl_tb.sv
/*
 * Testbench for the LUT index controller top level.
 * Clock, reset, random sum words, reference index function,
 * compare process for the sync and lut ports, and a timeout.
 */
`timescale 1ns/100ps
`include "cdp_lut_consts.svh"

module cdp_lut_ctrl_tb;

  import cdp_lut_pkg::*;

  localparam int N_RANGE     = 40;
  localparam int N_CLAMP     = 40;
  localparam int N_STALL     = 200;
  localparam int N_SHIFT     = 20;          // per shift value
  localparam int TOTAL_WORDS = N_RANGE + N_CLAMP + N_STALL + 3 * N_SHIFT;
  localparam int CYCLE_LIMIT = 40 * TOTAL_WORDS + 200;
  localparam int LANES   = `CDP_LUT_LANES;
  localparam int ELEMS   = `CDP_LUT_ELEMS;
  localparam int LANE_W  = `CDP_LUT_LANE_W;
  localparam int SUM_W   = `CDP_LUT_SUM_W;
  localparam int ENTRY_W = `CDP_LUT_ENTRY_W;
  localparam int INFO_W  = `CDP_LUT_INFO_W;

  typedef struct packed {
    entry_vec_t x_entry;
    info_vec_t  x_info;
    entry_vec_t y_entry;
    info_vec_t  y_info;
  } lut_result_t;

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  logic        sum_pvld;
  sum_pd_t     sum_pd;
  logic        sum_prdy;
  logic        sync_pvld;
  sum_pd_t     sync_pd;
  logic        sync_prdy;
  lut_start_t  le_start;
  lut_start_t  lo_start;
  logic [7:0]  le_index_select;
  logic [7:0]  lo_index_select;
  logic        lut_pvld;
  logic        lut_prdy;
  entry_vec_t  lut_x_entry;
  info_vec_t   lut_x_info;
  entry_vec_t  lut_y_entry;
  info_vec_t   lut_y_info;

  integer      seed = 32'h66c83f88;
  int          cycles = 0;
  bit          stall_en = 1'b0;
  logic [31:0] ready_bits;
  sum_pd_t     sync_q[$];                   // accepted words, sync side
  sum_pd_t     lut_q[$];                    // accepted words, lut side

  cdp_lut_ctrl cdp_lut_ctrl_inst (.*);

  initial nvdla_core_clk = 1'b0;
  always #10 nvdla_core_clk = ~nvdla_core_clk;

  ////////////////////////////////////////////////////////////
  // reference model

  // {entry, uflow, oflow, fraction} for one element
  function automatic logic [ENTRY_W+INFO_W-1:0] index_expect(input sum_t x,
      input lut_start_t start, input int shift, input int entries);
    longint d;
    longint idx;
    longint low;
    logic [15:0] frac;
    d = longint'(x) - longint'(start);
    if (d < 0) return {10'd0, 2'b10, 16'h0};
    idx = d >> shift;
    if (idx >= entries - 1) return {10'(entries - 1), 2'b01, 16'h0};
    low = d & ((64'sd1 << shift) - 1);
    if (shift <= 16) frac = 16'(low << (16 - shift));
    else frac = 16'(low >> (shift - 16));   // keep the top 16 bits
    return {10'(idx), 2'b00, frac};
  endfunction

  function automatic lut_result_t lut_reference(input sum_pd_t pd, input lut_start_t les,
      input lut_start_t los, input logic [7:0] lesel, input logic [7:0] losel);
    lut_result_t r;
    sum_t x;
    for (int i = 0; i < ELEMS; i++) begin
      x = pd[(i % LANES) * LANE_W + (i / LANES) * SUM_W +: SUM_W];  // lane i%4, half i/4
      {r.x_entry[i*ENTRY_W +: ENTRY_W], r.x_info[i*INFO_W +: INFO_W]} =
        index_expect(x, les, int'(lesel[4:0]), `CDP_LUT_LE_ENTRIES);
      {r.y_entry[i*ENTRY_W +: ENTRY_W], r.y_info[i*INFO_W +: INFO_W]} =
        index_expect(x, los, int'(losel[4:0]), `CDP_LUT_LO_ENTRIES);
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // checking and failure

  task automatic stop_failed();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [`CDP_LUT_PD_W-1:0] got,
      input logic [`CDP_LUT_PD_W-1:0] expected);
    if (got !== expected) begin
      $display("mismatch %s: got %h expected %h", name, got, expected);
      stop_failed();
    end
  endtask

  always @(negedge nvdla_core_clk) begin : compare
    sum_pd_t word;
    lut_result_t exp_r;
    if (sync_pvld && sync_prdy) begin
      if (sync_q.size() == 0) begin
        $display("sync transfer with no word outstanding");
        stop_failed();
      end else begin
        word = sync_q.pop_front();
        check_value("sync_pd", sync_pd, word);
      end
    end
    if (lut_pvld && lut_prdy) begin
      if (lut_q.size() == 0) begin
        $display("lut transfer with no word outstanding");
        stop_failed();
      end else begin
        word = lut_q.pop_front();
        exp_r = lut_reference(word, le_start, lo_start, le_index_select, lo_index_select);
        check_value("lut_x_entry", lut_x_entry, exp_r.x_entry);
        check_value("lut_x_info", lut_x_info, exp_r.x_info);
        check_value("lut_y_entry", lut_y_entry, exp_r.y_entry);
        check_value("lut_y_info", lut_y_info, exp_r.y_info);
      end
    end
    if (sum_pvld && sum_prdy) begin         // taken at the coming edge
      sync_q.push_back(sum_pd);
      lut_q.push_back(sum_pd);
    end
  end

  always @(posedge nvdla_core_clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_failed();
    end
  end

  // independent random back-pressure on both outputs
  always @(posedge nvdla_core_clk) begin
    ready_bits = $random(seed);
    sync_prdy <= stall_en ? ready_bits[0] : 1'b1;
    lut_prdy  <= stall_en ? ready_bits[1] : 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // stimulus

  function automatic int rand_range(input int lo, input int span);
    return lo + int'($unsigned($random(seed)) % span);
  endfunction

  task automatic send_word(input sum_pd_t pd);
    @(posedge nvdla_core_clk);
    sum_pvld <= 1'b1;
    sum_pd   <= pd;
    do @(negedge nvdla_core_clk); while (!sum_prdy);
  endtask

  task automatic send_words(input int count, input int lo, input int span);
    sum_pd_t pd;
    for (int w = 0; w < count; w++) begin
      for (int i = 0; i < ELEMS; i++) begin
        pd[(i % LANES) * LANE_W + (i / LANES) * SUM_W +: SUM_W] = sum_t'(rand_range(lo, span));
      end
      send_word(pd);
    end
    @(posedge nvdla_core_clk);
    sum_pvld <= 1'b0;
    while (sync_q.size() != 0 || lut_q.size() != 0) @(negedge nvdla_core_clk);
  endtask

  // only called while nothing is in flight
  task automatic set_config(input int les, input int los, input int lesh, input int losh);
    @(posedge nvdla_core_clk);
    le_start        <= lut_start_t'(les);
    lo_start        <= lut_start_t'(los);
    le_index_select <= {3'b101, 5'(lesh)};  // upper bits are ignored
    lo_index_select <= {3'b010, 5'(losh)};
    @(negedge nvdla_core_clk);
  endtask

  initial begin
    nvdla_core_rstn <= 1'b0;
    sum_pvld        <= 1'b0;
    sum_pd          <= '0;
    sync_prdy       <= 1'b1;
    lut_prdy        <= 1'b1;
    le_start        <= '0;
    lo_start        <= '0;
    le_index_select <= '0;
    lo_index_select <= '0;
    repeat (10) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(negedge nvdla_core_clk);
    check_value("sync_pvld", sync_pvld, 0);
    check_value("lut_pvld", lut_pvld, 0);
    check_value("sum_prdy", sum_prdy, 1);

    set_config(-1000, -2000, 4, 4);         // in range on both tables
    send_words(N_RANGE, -1000, 1024);
    set_config(0, 0, 2, 3);                 // full range mostly clamps
    send_words(N_CLAMP, -(1 << 20), 1 << 21);
    set_config(-4096, -8192, 6, 6);
    stall_en = 1'b1;
    send_words(N_STALL, -10000, 30000);
    stall_en = 1'b0;
    set_config(100, 50, 0, 0);
    send_words(N_SHIFT, 90, 100);
    set_config(-(1 << 20), -(1 << 20), 16, 16);
    send_words(N_SHIFT, -(1 << 20), 1 << 21);
    set_config(-(1 << 20), -(1 << 20), 20, 20);
    send_words(N_SHIFT, -(1 << 20), 1 << 21);

    repeat (4) @(negedge nvdla_core_clk);
    if (cdp_lut_ctrl_inst.u_assert.fail_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("bound handshake assertions failed %0d times",
               cdp_lut_ctrl_inst.u_assert.fail_count);
      stop_failed();
    end
  end

endmodule

//--- build.f
+incdir+rtl
rtl/cdp_lut_pkg.sv
rtl/cdp_lut_index.sv
rtl/cdp_lut_decode.sv
rtl/cdp_lut_result.sv
rtl/cdp_lut_ctrl.sv
test/cdp_lut_ctrl_assert.sv
test/cdp_lut_ctrl_tb.sv
